// ==== list.f ====
+incdir+verilog
verilog/icache_addr_pkg.sv
verilog/icache_ctrl_pkg.sv
verilog/icache_array.sv
verilog/icache_decode_stage.sv
verilog/icache_tag_lookup.sv
verilog/icache_tag_verify.sv
verilog/icache_top.sv
tb/icache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module icache_tb -o icache_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/icache_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

// ==== tb/icache_tb.sv ====
// Instruction cache testbench
`default_nettype none
`timescale 1ns/10ps

`include "icache_settings.svh"

module icache_tb;

  localparam int          CLK_PERIOD   = 40;
  localparam int          DRIVE_DELAY  = 2;
  localparam int          RESET_CYCLES = 4;
  localparam int          IDLE_CYCLES  = 5;
  localparam int          TEST_CYCLES  = 60;
  localparam int          INDEX_LSB    = `ICACHE_WORD_SEL_W + 2;
  localparam int          TAG_LSB      = INDEX_LSB + `ICACHE_INDEX_W;
  localparam int          BLOCK_BYTES  = `ICACHE_BLOCK_W / 8;
  localparam int          BLOCK_WORDS  = `ICACHE_BLOCK_W / `ICACHE_INSTR_W;
  localparam logic [31:0] FILL_PATTERN = 32'h5a5a0000;

  logic                       clk_i;
  logic                       reset_i;
  logic                       fetch_v_i;
  logic [`ICACHE_ADDR_W-1:0]  fetch_addr_i;
  logic                       yumi_o;
  logic [`ICACHE_INSTR_W-1:0] data_o;
  logic                       data_v_o;
  logic                       yumi_i;
  logic                       miss_v_o;
  logic [`ICACHE_ADDR_W-1:0]  miss_addr_o;
  logic                       fill_v_i;
  logic [`ICACHE_BLOCK_W-1:0] fill_data_i;

  // Stimulus table, one row per request
  string       test_name [$];
  logic [31:0] test_addr [$];
  logic        test_miss [$];
  bit          table_ready = 1'b0;

  int cycle_cnt    = 0;
  int fill_cycle   = 0;
  int error_count  = 0;
  int failed_tests = 0;
  int run_tests    = 0;

  // Reference model state
  logic [`ICACHE_TAG_W-1:0] model_tag   [`ICACHE_WAYS][`ICACHE_SETS];
  logic                     model_valid [`ICACHE_WAYS][`ICACHE_SETS];
  logic                     model_lru   [`ICACHE_SETS];

  icache_top DUT (
    .clk_i(clk_i), .reset_i(reset_i),
    .fetch_v_i(fetch_v_i), .fetch_addr_i(fetch_addr_i), .yumi_o(yumi_o),
    .data_o(data_o), .data_v_o(data_v_o), .yumi_i(yumi_i),
    .miss_v_o(miss_v_o), .miss_addr_o(miss_addr_o),
    .fill_v_i(fill_v_i), .fill_data_i(fill_data_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    cycle_cnt <= cycle_cnt + 1;

  //////////////////////////////////////////////////
  // Expected values
  //////////////////////////////////////////////////

  function automatic logic [31:0] block_base(input logic [31:0] addr);
    return addr & ~32'(BLOCK_BYTES - 1);
  endfunction

  // Every word of memory holds its own address XOR the pattern
  function automatic logic [31:0] expected_instr(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ FILL_PATTERN;
  endfunction

  function automatic logic [`ICACHE_BLOCK_W-1:0] make_block(input logic [31:0] base);
    logic [`ICACHE_BLOCK_W-1:0] blk;
    for (int i = 0; i < BLOCK_WORDS; i++)
      blk[i*`ICACHE_INSTR_W +: `ICACHE_INSTR_W] = (base + 32'(4 * i)) ^ FILL_PATTERN;
    return blk;
  endfunction

  task automatic clear_model();
    for (int s = 0; s < `ICACHE_SETS; s++)
    begin
      model_lru[s] = 1'b0;
      for (int w = 0; w < `ICACHE_WAYS; w++)
        model_valid[w][s] = 1'b0;
    end
  endtask

  // Two-way LRU, a miss fills the first invalid way or else the LRU way
  function automatic logic model_access(input logic [31:0] addr);
    logic [`ICACHE_INDEX_W-1:0] set;
    logic [`ICACHE_TAG_W-1:0]   tag;
    int                         way;
    logic                       miss;
    set = addr[INDEX_LSB +: `ICACHE_INDEX_W];
    tag = addr[TAG_LSB +: `ICACHE_TAG_W];
    way = -1;
    for (int w = 0; w < `ICACHE_WAYS; w++)
      if (model_valid[w][set] && model_tag[w][set] == tag)
        way = w;
    miss = (way < 0);
    if (miss)
    begin
      way = model_lru[set] ? 1 : 0;
      for (int w = `ICACHE_WAYS - 1; w >= 0; w--)
        if (!model_valid[w][set])
          way = w;
      model_valid[way][set] = 1'b1;
      model_tag[way][set]   = tag;
    end
    model_lru[set] = (way == 0);
    return miss;
  endfunction

  //////////////////////////////////////////////////
  // Checking and reporting
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input logic [31:0] addr, input int errors_before);
    run_tests++;
    if (error_count == errors_before)
      $display("[ok]    %-18s addr %h", name, addr);
    else
    begin
      failed_tests++;
      $display("[error] %-18s addr %h, %0d mismatches", name, addr, error_count - errors_before);
    end
  endtask

  task automatic add_test(input string name, input logic [31:0] addr, input logic miss);
    test_name.push_back(name);
    test_addr.push_back(addr);
    test_miss.push_back(miss);
  endtask

  // Set 4 holds tags 0x10, 0x20 and 0x30 in turn
  task automatic load_table();
    add_test("a_w0_cold",     32'h0000_1040, 1'b1);
    add_test("a_w1",          32'h0000_1044, 1'b0);
    add_test("a_w2",          32'h0000_1048, 1'b0);
    add_test("a_w3_unaligned", 32'h0000_104e, 1'b0);
    add_test("b_cold",        32'h0000_2040, 1'b1);
    add_test("a_alt",         32'h0000_1044, 1'b0);
    add_test("b_alt",         32'h0000_204c, 1'b0);
    add_test("a_alt2",        32'h0000_1040, 1'b0);
    add_test("b_alt2",        32'h0000_2048, 1'b0);
    add_test("c_evicts_a",    32'h0000_3040, 1'b1);
    add_test("b_resident",    32'h0000_2044, 1'b0);
    add_test("a_evicted",     32'h0000_1040, 1'b1);
    add_test("b_still",       32'h0000_2040, 1'b0);
    add_test("d_cold",        32'habcd_e7f0, 1'b1);
    add_test("d_hit",         32'habcd_e7f4, 1'b0);
    add_test("set0_cold",     32'h0000_0008, 1'b1);
  endtask

  task automatic check_idle();
    int errors_before;
    errors_before = error_count;
    repeat (IDLE_CYCLES)
    begin
      @(negedge clk_i);
      check_value("idle_after_reset", "data_v_o", 32'd0, {31'b0, data_v_o});
      check_value("idle_after_reset", "miss_v_o", 32'd0, {31'b0, miss_v_o});
      check_value("idle_after_reset", "yumi_o", 32'd0, {31'b0, yumi_o});
    end
    report_test("idle_after_reset", 32'd0, errors_before);
  endtask

  //////////////////////////////////////////////////
  // Request sequence
  //////////////////////////////////////////////////

  // Inputs change after the rising edge, outputs are sampled at the falling edge
  task automatic run_test(input int t);
    string       name;
    logic [31:0] addr;
    logic [31:0] held_data;
    logic        saw_miss;
    int          accept_cycle;
    int          stall;
    int          errors_before;
    name          = test_name[t];
    addr          = test_addr[t];
    saw_miss      = 1'b0;
    errors_before = error_count;
    check_value(name, "model miss flag", {31'b0, test_miss[t]}, {31'b0, model_access(addr)});
    @(posedge clk_i);
    #DRIVE_DELAY;
    fetch_v_i    = 1'b1;
    fetch_addr_i = addr;
    @(negedge clk_i);
    while (!yumi_o)
      @(negedge clk_i);
    accept_cycle = cycle_cnt;
    @(posedge clk_i);
    #DRIVE_DELAY;
    fetch_v_i = 1'b0;
    @(negedge clk_i);
    while (!data_v_o)
    begin
      if (miss_v_o && !saw_miss)
      begin
        saw_miss = 1'b1;
        check_value(name, "miss_addr_o", block_base(addr), miss_addr_o);
      end
      @(negedge clk_i);
    end
    check_value(name, "miss flag", {31'b0, test_miss[t]}, {31'b0, saw_miss});
    if (saw_miss)
      check_value(name, "fill to data cycles", 32'd2, cycle_cnt - fill_cycle);
    else
      check_value(name, "hit latency", 32'd2, cycle_cnt - accept_cycle);
    check_value(name, "data_o", expected_instr(addr), data_o);
    held_data = data_o;
    // Back-pressure, the output must hold still
    stall = $urandom_range(0, 4);
    repeat (stall)
    begin
      @(negedge clk_i);
      check_value(name, "data_v_o in stall", 32'd1, {31'b0, data_v_o});
      check_value(name, "data_o in stall", held_data, data_o);
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    yumi_i = 1'b1;
    @(negedge clk_i);
    check_value(name, "data_o at dequeue", held_data, data_o);
    @(posedge clk_i);
    #DRIVE_DELAY;
    yumi_i = 1'b0;
    // A second delivery would mean a duplicated request
    @(negedge clk_i);
    check_value(name, "data_v_o after dequeue", 32'd0, {31'b0, data_v_o});
    report_test(name, addr, errors_before);
  endtask

  //////////////////////////////////////////////////
  // Fill responder
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] base;
    int          delay;
    fill_v_i    = 1'b0;
    fill_data_i = '0;
    forever
    begin
      @(negedge clk_i);
      if (miss_v_o)
      begin
        base  = miss_addr_o;
        delay = $urandom_range(0, 6);
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        #DRIVE_DELAY;
        fill_v_i    = 1'b1;
        fill_data_i = make_block(base);
        fill_cycle  = cycle_cnt;
        @(posedge clk_i);
        #DRIVE_DELAY;
        fill_v_i = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'hd312));
    reset_i      = 1'b1;
    fetch_v_i    = 1'b0;
    fetch_addr_i = '0;
    yumi_i       = 1'b0;
    clear_model();
    load_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    reset_i = 1'b0;
    check_idle();
    for (int t = 0; t < test_addr.size(); t++)
      run_test(t);
    $display("Summary: %0d tests, %0d with errors, %0d mismatches",
             run_tests, failed_tests, error_count);
    if (error_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    wait (table_ready);
    repeat (RESET_CYCLES + IDLE_CYCLES + TEST_CYCLES * test_addr.size()) @(posedge clk_i);
    $display("Timeout: the request sequence did not complete within its cycle budget");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/icache_addr_pkg.sv ====
// Fetch address and block types
`default_nettype none

`include "icache_settings.svh"

package icache_addr_pkg;

  //////////////////////////////////////////////////
  // Fetch address
  //////////////////////////////////////////////////

  // Field layout, most significant first
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]      tag;
    logic [`ICACHE_INDEX_W-1:0]    index;
    logic [`ICACHE_WORD_SEL_W-1:0] word_sel;
    logic [1:0]                    byte_off;
  } fetch_fields_s;

  // Ports move the raw word, the stages decode it through the fields
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0] raw;
    fetch_fields_s             fields;
  } fetch_addr_u;

  //////////////////////////////////////////////////
  // Cache block
  //////////////////////////////////////////////////

  // Word 0 holds the lowest instruction address
  typedef logic [`ICACHE_BLOCK_W/`ICACHE_INSTR_W-1:0][`ICACHE_INSTR_W-1:0] block_t;

endpackage

`default_nettype wire

// ==== verilog/icache_array.sv ====
// Tag, valid and data storage
`default_nettype none
`timescale 1ns/10ps

`include "icache_settings.svh"

module icache_array (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic                                         rd_v_i,
  input  logic [`ICACHE_INDEX_W-1:0]                   rd_index_i,
  input  logic                                         wr_v_i,
  input  icache_ctrl_pkg::way_t                        wr_way_i,
  input  logic [`ICACHE_INDEX_W-1:0]                   wr_index_i,
  input  logic [`ICACHE_TAG_W-1:0]                     wr_tag_i,
  input  icache_addr_pkg::block_t                      wr_data_i,
  output logic [`ICACHE_WAYS-1:0][`ICACHE_TAG_W-1:0]   tag_o,
  output icache_ctrl_pkg::way_vec_t                    valid_o,
  output icache_addr_pkg::block_t [`ICACHE_WAYS-1:0]   data_o
);

  logic [`ICACHE_TAG_W-1:0]                tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
  icache_addr_pkg::block_t                 data_mem [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_r;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // Fill writes a whole block and its tag into one way
  always_ff @(posedge clk_i)
  begin
    if (wr_v_i)
    begin
      tag_mem[wr_way_i][wr_index_i]  <= wr_tag_i;
      data_mem[wr_way_i][wr_index_i] <= wr_data_i;
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Output register keeps the last read until the next one
  always_ff @(posedge clk_i)
  begin
    if (rd_v_i)
    begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        tag_o[w]  <= tag_mem[w][rd_index_i];
        data_o[w] <= data_mem[w][rd_index_i];
      end
    end
  end

  // Valid bits live in flops so reset empties the cache
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r <= '0;
      valid_o <= '0;
    end
    else
    begin
      if (wr_v_i)
        valid_r[wr_way_i][wr_index_i] <= 1'b1;
      if (rd_v_i)
      begin
        for (int w = 0; w < `ICACHE_WAYS; w++)
          valid_o[w] <= valid_r[w][rd_index_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/icache_ctrl_pkg.sv ====
// Miss control types
`default_nettype none

`include "icache_settings.svh"

package icache_ctrl_pkg;

  //////////////////////////////////////////////////
  // Miss state machine
  //////////////////////////////////////////////////

  // e_ready   serves requests from the pipeline
  // e_miss    waits for the block fill
  // e_recover re-reads the arrays after the fill
  typedef enum logic [1:0] {
    e_ready,
    e_miss,
    e_recover
  } miss_state_e;

  //////////////////////////////////////////////////
  // Way selection
  //////////////////////////////////////////////////

  // Encoded way number
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;

  // One bit per way, used for hit and valid vectors
  typedef logic [`ICACHE_WAYS-1:0] way_vec_t;

endpackage

`default_nettype wire

// ==== verilog/icache_decode_stage.sv ====
// Fetch decode stage
`default_nettype none
`timescale 1ns/10ps

`include "icache_settings.svh"

module icache_decode_stage (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         fetch_v_i,
  input  logic [`ICACHE_ADDR_W-1:0]    fetch_addr_i,
  output logic                         yumi_o,
  input  icache_ctrl_pkg::miss_state_e state_i,
  input  logic                         tl_v_i,
  input  logic [`ICACHE_INDEX_W-1:0]   tl_index_i,
  input  logic                         tv_we_i,
  output logic                         tl_we_o,
  output logic                         rd_v_o,
  output logic [`ICACHE_INDEX_W-1:0]   rd_index_o
);

  icache_addr_pkg::fetch_addr_u req_addr;
  logic                         is_ready;
  logic                         is_recover;

  assign req_addr.raw = fetch_addr_i;
  assign is_ready     = (state_i == icache_ctrl_pkg::e_ready);
  assign is_recover   = (state_i == icache_ctrl_pkg::e_recover);

  //////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////

  // TL must be free or moving on to TV in this cycle
  assign tl_we_o = is_ready & fetch_v_i & (~tl_v_i | tv_we_i);
  assign yumi_o  = tl_we_o;

  //////////////////////////////////////////////////
  // Array read
  //////////////////////////////////////////////////

  // Recover refreshes the set that the pipeline is waiting on
  assign rd_v_o     = tl_we_o | is_recover;
  assign rd_index_o = is_recover ? tl_index_i : req_addr.fields.index;

endmodule

`default_nettype wire

// ==== verilog/icache_settings.svh ====
// Instruction cache geometry
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

//////////////////////////////////////////////////
// Organization
//////////////////////////////////////////////////

`define ICACHE_SETS 16
`define ICACHE_WAYS 2

// One block carries four instructions
`define ICACHE_BLOCK_W 128
`define ICACHE_INSTR_W 32

//////////////////////////////////////////////////
// Address fields
//////////////////////////////////////////////////

`define ICACHE_ADDR_W 32
`define ICACHE_INDEX_W 4
`define ICACHE_WORD_SEL_W 2

// Two byte-offset bits sit below the word select
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_WORD_SEL_W - 2)

`endif

// ==== verilog/icache_tag_lookup.sv ====
// Tag lookup stage
`default_nettype none
`timescale 1ns/10ps

`include "icache_settings.svh"

module icache_tag_lookup (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       tl_we_i,
  input  logic [`ICACHE_ADDR_W-1:0]                  fetch_addr_i,
  input  logic                                       tv_we_i,
  input  logic [`ICACHE_WAYS-1:0][`ICACHE_TAG_W-1:0] tag_i,
  input  icache_ctrl_pkg::way_vec_t                  valid_i,
  output logic                                       tl_v_o,
  output logic [`ICACHE_ADDR_W-1:0]                  tl_addr_o,
  output icache_ctrl_pkg::way_vec_t                  hit_o
);

  icache_addr_pkg::fetch_addr_u tl_addr_r;
  logic                         tl_v_r;

  //////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////

  // A new load wins over TV taking the old entry
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tl_v_r <= 1'b0;
    else if (tl_we_i)
      tl_v_r <= 1'b1;
    else if (tv_we_i)
      tl_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (tl_we_i)
      tl_addr_r.raw <= fetch_addr_i;
  end

  assign tl_v_o    = tl_v_r;
  assign tl_addr_o = tl_addr_r.raw;

  //////////////////////////////////////////////////
  // Tag compare
  //////////////////////////////////////////////////

  // Array outputs belong to this entry's set in every cycle TV can load
  always_comb
  begin
    for (int w = 0; w < `ICACHE_WAYS; w++)
      hit_o[w] = valid_i[w] & (tag_i[w] == tl_addr_r.fields.tag);
  end

endmodule

`default_nettype wire

// ==== verilog/icache_tag_verify.sv ====
// Tag verify stage and miss control
`default_nettype none
`timescale 1ns/10ps

`include "icache_settings.svh"

module icache_tag_verify (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic                                     tl_v_i,
  input  logic [`ICACHE_ADDR_W-1:0]                tl_addr_i,
  input  icache_ctrl_pkg::way_vec_t                hit_i,
  input  icache_addr_pkg::block_t [`ICACHE_WAYS-1:0] data_i,
  input  logic                                     yumi_i,
  input  logic                                     fill_v_i,
  input  icache_addr_pkg::block_t                  fill_data_i,
  output logic                                     tv_we_o,
  output icache_ctrl_pkg::miss_state_e             state_o,
  output logic [`ICACHE_INSTR_W-1:0]               data_o,
  output logic                                     data_v_o,
  output logic                                     miss_v_o,
  output logic [`ICACHE_ADDR_W-1:0]                miss_addr_o,
  output logic                                     wr_v_o,
  output icache_ctrl_pkg::way_t                    wr_way_o,
  output logic [`ICACHE_INDEX_W-1:0]               wr_index_o,
  output logic [`ICACHE_TAG_W-1:0]                 wr_tag_o,
  input  icache_ctrl_pkg::way_vec_t                valid_i,
  output logic [`ICACHE_INDEX_W-1:0]               tl_index_o
);

  icache_ctrl_pkg::miss_state_e               state_r;
  icache_ctrl_pkg::miss_state_e               state_n;
  icache_addr_pkg::fetch_addr_u               tl_addr;
  icache_addr_pkg::fetch_addr_u               tv_addr_r;
  icache_addr_pkg::fetch_addr_u               miss_addr;
  icache_addr_pkg::block_t [`ICACHE_WAYS-1:0] tv_data_r;
  icache_ctrl_pkg::way_vec_t                  tv_hit_r;
  icache_ctrl_pkg::way_t                      hit_way;
  icache_ctrl_pkg::way_t                      lru_way;
  icache_ctrl_pkg::way_t                      victim_n;
  icache_ctrl_pkg::way_t                      victim_r;
  logic [`ICACHE_SETS-1:0]                    lru_r;
  logic                                       tv_v_r;
  logic                                       is_ready;
  logic                                       tv_deq;

  assign tl_addr.raw = tl_addr_i;
  assign is_ready    = (state_r == icache_ctrl_pkg::e_ready);

  //////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////

  assign data_v_o = tv_v_r & is_ready & (|tv_hit_r);
  assign tv_deq   = data_v_o & yumi_i;
  assign tv_we_o  = tl_v_i & is_ready & (~tv_v_r | tv_deq);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tv_v_r <= 1'b0;
    else if (tv_we_o)
      tv_v_r <= 1'b1;
    else if (tv_deq)
      tv_v_r <= 1'b0;
  end

  // The fill turns a pending miss into a hit on the victim way
  always_ff @(posedge clk_i)
  begin
    if (tv_we_o)
    begin
      tv_addr_r.raw <= tl_addr_i;
      tv_hit_r      <= hit_i;
      tv_data_r     <= data_i;
      if (!(|hit_i))
        victim_r <= victim_n;
    end
    else if (wr_v_o)
    begin
      tv_hit_r            <= icache_ctrl_pkg::way_vec_t'(1) << victim_r;
      tv_data_r[victim_r] <= fill_data_i;
    end
  end

  //////////////////////////////////////////////////
  // Instruction select
  //////////////////////////////////////////////////

  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
      if (tv_hit_r[w])
        hit_way = icache_ctrl_pkg::way_t'(w);
  end

  assign data_o = tv_data_r[hit_way][tv_addr_r.fields.word_sel];

  //////////////////////////////////////////////////
  // Replacement
  //////////////////////////////////////////////////

  // Each bit names the least recently used way of its set
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      lru_r <= '0;
    else if (tv_deq)
      lru_r[tv_addr_r.fields.index] <= ~hit_way;
  end

  // Forward a same-set update that lands on this edge, then prefer a free way
  always_comb
  begin
    if (tv_deq && (tv_addr_r.fields.index == tl_addr.fields.index))
      lru_way = ~hit_way;
    else
      lru_way = lru_r[tl_addr.fields.index];
    victim_n = lru_way;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--)
      if (!valid_i[w])
        victim_n = icache_ctrl_pkg::way_t'(w);
  end

  //////////////////////////////////////////////////
  // Miss state machine
  //////////////////////////////////////////////////

  always_comb
  begin
    case (state_r)
      icache_ctrl_pkg::e_ready:
        state_n = (tv_we_o && !(|hit_i)) ? icache_ctrl_pkg::e_miss : icache_ctrl_pkg::e_ready;
      icache_ctrl_pkg::e_miss:
        state_n = fill_v_i ? icache_ctrl_pkg::e_recover : icache_ctrl_pkg::e_miss;
      default:
        state_n = icache_ctrl_pkg::e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= icache_ctrl_pkg::e_ready;
    else
      state_r <= state_n;
  end

  assign state_o  = state_r;
  assign miss_v_o = (state_r == icache_ctrl_pkg::e_miss);

  // Block-aligned request address
  always_comb
  begin
    miss_addr                 = tv_addr_r;
    miss_addr.fields.word_sel = '0;
    miss_addr.fields.byte_off = '0;
  end

  assign miss_addr_o = miss_addr.raw;

  // Fill write into the chosen way
  assign wr_v_o     = fill_v_i & miss_v_o;
  assign wr_way_o   = victim_r;
  assign wr_index_o = tv_addr_r.fields.index;
  assign wr_tag_o   = tv_addr_r.fields.tag;

  // Recover re-reads the TL set when an entry waits there, else the TV set
  assign tl_index_o = tl_v_i ? tl_addr.fields.index : tv_addr_r.fields.index;

endmodule

`default_nettype wire

// ==== verilog/icache_top.sv ====
// Instruction cache top level
`default_nettype none
`timescale 1ns/10ps

`include "icache_settings.svh"

module icache_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      fetch_v_i,
  input  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i,
  output logic                      yumi_o,
  output logic [`ICACHE_INSTR_W-1:0] data_o,
  output logic                      data_v_o,
  input  logic                      yumi_i,
  output logic                      miss_v_o,
  output logic [`ICACHE_ADDR_W-1:0] miss_addr_o,
  input  logic                      fill_v_i,
  input  icache_addr_pkg::block_t   fill_data_i
);

  // Stage control
  logic                         tl_we;
  logic                         tv_we;
  logic                         tl_v;
  logic [`ICACHE_ADDR_W-1:0]    tl_addr;
  logic [`ICACHE_INDEX_W-1:0]   tl_index;
  icache_ctrl_pkg::way_vec_t    hit;
  icache_ctrl_pkg::miss_state_e state;

  // Array ports
  logic                                       rd_v;
  logic [`ICACHE_INDEX_W-1:0]                 rd_index;
  logic                                       wr_v;
  icache_ctrl_pkg::way_t                      wr_way;
  logic [`ICACHE_INDEX_W-1:0]                 wr_index;
  logic [`ICACHE_TAG_W-1:0]                   wr_tag;
  logic [`ICACHE_WAYS-1:0][`ICACHE_TAG_W-1:0] arr_tag;
  icache_ctrl_pkg::way_vec_t                  arr_valid;
  icache_addr_pkg::block_t [`ICACHE_WAYS-1:0] arr_data;

  //////////////////////////////////////////////////
  // Pipeline stages
  //////////////////////////////////////////////////

  icache_decode_stage decode (
    .clk_i(clk_i), .reset_i(reset_i),
    .fetch_v_i(fetch_v_i), .fetch_addr_i(fetch_addr_i), .yumi_o(yumi_o),
    .state_i(state), .tl_v_i(tl_v), .tl_index_i(tl_index), .tv_we_i(tv_we),
    .tl_we_o(tl_we), .rd_v_o(rd_v), .rd_index_o(rd_index)
  );

  icache_tag_lookup tl (
    .clk_i(clk_i), .reset_i(reset_i),
    .tl_we_i(tl_we), .fetch_addr_i(fetch_addr_i), .tv_we_i(tv_we),
    .tag_i(arr_tag), .valid_i(arr_valid),
    .tl_v_o(tl_v), .tl_addr_o(tl_addr), .hit_o(hit)
  );

  icache_tag_verify tv (
    .clk_i(clk_i), .reset_i(reset_i),
    .tl_v_i(tl_v), .tl_addr_i(tl_addr), .hit_i(hit), .data_i(arr_data),
    .yumi_i(yumi_i), .fill_v_i(fill_v_i), .fill_data_i(fill_data_i),
    .tv_we_o(tv_we), .state_o(state), .data_o(data_o), .data_v_o(data_v_o),
    .miss_v_o(miss_v_o), .miss_addr_o(miss_addr_o),
    .wr_v_o(wr_v), .wr_way_o(wr_way), .wr_index_o(wr_index), .wr_tag_o(wr_tag),
    .valid_i(arr_valid), .tl_index_o(tl_index)
  );

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  icache_array arrays (
    .clk_i(clk_i), .reset_i(reset_i),
    .rd_v_i(rd_v), .rd_index_i(rd_index),
    .wr_v_i(wr_v), .wr_way_i(wr_way), .wr_index_i(wr_index),
    .wr_tag_i(wr_tag), .wr_data_i(fill_data_i),
    .tag_o(arr_tag), .valid_o(arr_valid), .data_o(arr_data)
  );

endmodule

`default_nettype wire
